// File: ooo_backend.f
common/rob_pkg.sv
rob/reorder_buffer.sv
rtl/dispatch_stage.sv
rtl/exec_unit.sv
rtl/commit_stage.sv
rtl/ooo_backend.sv
sim/ooo_backend_assert.sv
sim/ooo_backend_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := ooo_backend_tb
FILELIST  := ooo_backend.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/ooo_backend_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_backend_tb import rob_pkg::*; ();

    localparam int MAX_ROWS = 48;
    localparam int TIMEOUT  = 2000;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  in_valid;
    op_t                   in_op;
    logic [REG_ADDR_W-1:0] in_rd;
    logic [XLEN-1:0]       in_a;
    logic [XLEN-1:0]       in_b;
    logic [XLEN-1:0]       in_target;
    logic                  in_ready;
    logic                  commit_valid;
    op_t                   commit_op;
    logic [REG_ADDR_W-1:0] commit_rd;
    logic [XLEN-1:0]       commit_value;
    logic                  redirect_valid;
    logic [XLEN-1:0]       redirect_pc;
    logic [REG_ADDR_W-1:0] rf_addr;
    logic [XLEN-1:0]       rf_data;

    // Stimulus table
    op_t                   t_op     [MAX_ROWS];
    logic [REG_ADDR_W-1:0] t_rd     [MAX_ROWS];
    logic [XLEN-1:0]       t_a      [MAX_ROWS];
    logic [XLEN-1:0]       t_b      [MAX_ROWS];
    logic [XLEN-1:0]       t_target [MAX_ROWS];
    logic                  t_shadow [MAX_ROWS];
    int                    n_rows = 0;

    // Expected commits from the reference model
    op_t                   exp_op       [MAX_ROWS];
    logic [REG_ADDR_W-1:0] exp_rd       [MAX_ROWS];
    logic [XLEN-1:0]       exp_value    [MAX_ROWS];
    logic [XLEN-1:0]       exp_target   [MAX_ROWS];
    logic                  exp_redirect [MAX_ROWS];
    logic [XLEN-1:0]       model_rf     [2**REG_ADDR_W];
    int                    n_exp = 0;
    int                    exp_idx = 0;

    int          redirect_count = 0;
    int          redirects_due = 0;
    logic [15:0] lfsr_state = 16'd40212;

    ooo_backend i_ooo_backend (.*);

    bind reorder_buffer ooo_backend_assert #(.ROB_ENTRIES(ROB_ENTRIES)) i_rob_assert (
        .clk            (clk),
        .reset          (reset),
        .full           (full),
        .alloc_valid    (alloc_valid),
        .count          (count),
        .entry_valid    (entry_valid),
        .entry_ready    (entry_ready),
        .cdb_fast_valid (cdb_fast_valid),
        .cdb_fast_tag   (cdb_fast_tag),
        .cdb_slow_valid (cdb_slow_valid),
        .cdb_slow_tag   (cdb_slow_tag),
        .flush          (flush),
        .head_valid     (head_valid)
    );

    always #20 clk = ~clk;

    task automatic stop_on_error(input string line);
        $display("Something failed");
        $display("%s", line);
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_op(input string name, input op_t got, input op_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] got,
                             input logic [REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_pc(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [XLEN-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[XLEN-2:0], lfsr_state[0]};
        end
    endtask

    task automatic add_row(input op_t op, input logic [REG_ADDR_W-1:0] rd,
                           input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                           input logic [XLEN-1:0] target, input logic shadow);
        t_op[n_rows]     = op;
        t_rd[n_rows]     = rd;
        t_a[n_rows]      = a;
        t_b[n_rows]      = b;
        t_target[n_rows] = target;
        t_shadow[n_rows] = shadow;
        n_rows++;
    endtask

    function automatic logic row_redirects(input int r);
        return (t_op[r] == op_jal) || ((t_op[r] == op_br) && (t_a[r] == t_b[r]));
    endfunction

    // Architectural effect of each non-shadow row, in program order
    task automatic build_model();
        logic [XLEN-1:0] v;
        for (int i = 0; i < 2**REG_ADDR_W; i++) begin
            model_rf[i] = '0;
        end
        for (int r = 0; r < n_rows; r++) begin
            if (!t_shadow[r]) begin
                case (t_op[r])
                    op_add:  v = t_a[r] + t_b[r];
                    op_xor:  v = t_a[r] ^ t_b[r];
                    op_mul:  v = t_a[r] * t_b[r];
                    op_br:   v = (t_a[r] == t_b[r]) ? 32'd1 : 32'd0;
                    default: v = t_a[r];
                endcase
                exp_op[n_exp]       = t_op[r];
                exp_rd[n_exp]       = t_rd[r];
                exp_value[n_exp]    = v;
                exp_target[n_exp]   = t_target[r];
                exp_redirect[n_exp] = row_redirects(r);
                n_exp++;
                if (t_op[r] != op_br && t_rd[r] != '0) begin
                    model_rf[t_rd[r]] = v;
                end
            end
        end
    endtask

    // Commit and redirect monitor
    always @(negedge clk) begin
        if (!reset) begin
            if (redirect_valid && !commit_valid) begin
                stop_on_error("redirect raised without a matching commit");
            end
            if (commit_valid) begin
                if (exp_idx >= n_exp) begin
                    stop_on_error("commit seen after all expected commits");
                end
                check_op("commit_op", commit_op, exp_op[exp_idx]);
                check_reg("commit_rd", commit_rd, exp_rd[exp_idx]);
                check_word("commit_value", commit_value, exp_value[exp_idx]);
                if (exp_redirect[exp_idx]) begin
                    if (!redirect_valid) begin
                        stop_on_error("taken branch or jump committed without redirect");
                    end
                    check_pc("redirect_pc", redirect_pc, exp_target[exp_idx]);
                    redirect_count++;
                end else if (redirect_valid) begin
                    stop_on_error("redirect raised for a not-taken branch or plain op");
                end
                exp_idx++;
            end
        end
    end

    // Returns skip high when a shadow row lost its chance to the redirect
    task automatic wait_ready(input logic shadow, output logic skip);
        int n;
        n = 0;
        skip = 1'b0;
        while (!in_ready) begin
            if (shadow && redirect_count >= redirects_due) begin
                skip = 1'b1;
                break;
            end
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                stop_on_error("timeout waiting for in_ready");
            end
        end
        if (shadow && redirect_count >= redirects_due) begin
            skip = 1'b1;
        end
    endtask

    task automatic wait_redirects();
        int n;
        n = 0;
        while (redirect_count < redirects_due) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                stop_on_error("timeout waiting for redirect");
            end
        end
    endtask

    task automatic wait_commits();
        int n;
        n = 0;
        while (exp_idx < n_exp) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                stop_on_error("timeout waiting for the remaining commits");
            end
        end
    endtask

    initial begin
        logic [XLEN-1:0] ra;
        logic [XLEN-1:0] rb;
        logic            skip;

        reset     = 1'b1;
        in_valid  = 1'b0;
        in_op     = op_add;
        in_rd     = '0;
        in_a      = '0;
        in_b      = '0;
        in_target = '0;
        rf_addr   = '0;

        // Mul followed by faster adds, then branches with their shadows
        add_row(op_add, 3'd1, 32'd5, 32'd7, '0, 1'b0);
        add_row(op_mul, 3'd2, 32'd1234, 32'd5678, '0, 1'b0);
        add_row(op_add, 3'd3, 32'd3, 32'd4, '0, 1'b0);
        add_row(op_xor, 3'd4, 32'hf0f0_1234, 32'h0ff0_ffff, '0, 1'b0);
        add_row(op_br,  3'd0, 32'd1, 32'd2, 32'h0000_0100, 1'b0);
        take_bits(32, ra);
        take_bits(32, rb);
        add_row(op_add, 3'd5, ra, rb, '0, 1'b0);
        add_row(op_br,  3'd0, 32'd9, 32'd9, 32'h0000_0200, 1'b0);
        add_row(op_add, 3'd1, 32'hdead, 32'hbeef, '0, 1'b1);
        add_row(op_mul, 3'd2, 32'd77, 32'd88, '0, 1'b1);
        add_row(op_xor, 3'd6, 32'h5555, 32'haaaa, '0, 1'b1);
        take_bits(16, ra);
        add_row(op_add, 3'd6, ra, 32'd100, '0, 1'b0);
        add_row(op_jal, 3'd7, 32'h0000_1004, '0, 32'h0000_0300, 1'b0);
        add_row(op_mul, 3'd3, 32'd11, 32'd13, '0, 1'b1);
        add_row(op_add, 3'd4, 32'd1, 32'd1, '0, 1'b1);
        // Multiply burst deeper than the buffer
        for (int i = 0; i < 11; i++) begin
            take_bits(20, ra);
            take_bits(12, rb);
            add_row(op_mul, REG_ADDR_W'(i % 7 + 1), ra, rb, '0, 1'b0);
        end
        add_row(op_add, 3'd0, 32'd42, 32'd1, '0, 1'b0);
        build_model();

        repeat (8) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        for (int r = 0; r < n_rows; r++) begin
            if (!t_shadow[r]) begin
                wait_redirects();
            end
            wait_ready(t_shadow[r], skip);
            if (!skip) begin
                in_valid  = 1'b1;
                in_op     = t_op[r];
                in_rd     = t_rd[r];
                in_a      = t_a[r];
                in_b      = t_b[r];
                in_target = t_target[r];
                if (!t_shadow[r] && row_redirects(r)) begin
                    redirects_due++;
                end
                @(negedge clk);
                in_valid = 1'b0;
            end
        end

        wait_commits();

        for (int i = 0; i < 2**REG_ADDR_W; i++) begin
            @(negedge clk);
            rf_addr = REG_ADDR_W'(i);
            #1;
            check_word($sformatf("rf_data[%0d]", i), rf_data, model_rf[i]);
        end

        $display("Everything OK");
        $finish;
    end

endmodule : ooo_backend_tb

`default_nettype wire

// File: sim/ooo_backend_assert.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_backend_assert #(
    parameter int ROB_ENTRIES = 8
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             full,
    input  logic                             alloc_valid,
    input  logic [$clog2(ROB_ENTRIES):0]     count,
    input  logic [ROB_ENTRIES-1:0]           entry_valid,
    input  logic [ROB_ENTRIES-1:0]           entry_ready,
    input  logic                             cdb_fast_valid,
    input  logic [$clog2(ROB_ENTRIES)-1:0]   cdb_fast_tag,
    input  logic                             cdb_slow_valid,
    input  logic [$clog2(ROB_ENTRIES)-1:0]   cdb_slow_tag,
    input  logic                             flush,
    input  logic                             head_valid
);

    // Dispatch must not allocate into a full buffer
    no_alloc_when_full: assert property (@(posedge clk) disable iff (reset)
        !(full && alloc_valid))
        else $error("allocation while buffer full");

    occupancy_bound: assert property (@(posedge clk) disable iff (reset)
        count <= ROB_ENTRIES)
        else $error("occupancy above buffer depth");

    // Each result is delivered once to a waiting entry
    fast_hits_waiting: assert property (@(posedge clk) disable iff (reset)
        (cdb_fast_valid && entry_valid[cdb_fast_tag]) |-> !entry_ready[cdb_fast_tag])
        else $error("fast bus result for an entry already ready");

    slow_hits_waiting: assert property (@(posedge clk) disable iff (reset)
        (cdb_slow_valid && entry_valid[cdb_slow_tag]) |-> !entry_ready[cdb_slow_tag])
        else $error("slow bus result for an entry already ready");

    flush_empties: assert property (@(posedge clk) disable iff (reset)
        flush |=> !head_valid)
        else $error("head still valid after flush");

endmodule : ooo_backend_assert

`default_nettype wire

// File: rtl/ooo_backend.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_backend import rob_pkg::*; #(
    parameter int ROB_ENTRIES = 8,
    parameter int MUL_LATENCY = 3
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   in_valid,
    input  op_t                    in_op,
    input  logic [REG_ADDR_W-1:0]  in_rd,
    input  logic [XLEN-1:0]        in_a,
    input  logic [XLEN-1:0]        in_b,
    input  logic [XLEN-1:0]        in_target,
    output logic                   in_ready,

    output logic                   commit_valid,
    output op_t                    commit_op,
    output logic [REG_ADDR_W-1:0]  commit_rd,
    output logic [XLEN-1:0]        commit_value,
    output logic                   redirect_valid,
    output logic [XLEN-1:0]        redirect_pc,

    input  logic [REG_ADDR_W-1:0]  rf_addr,
    output logic [XLEN-1:0]        rf_data
);

    localparam int TAG_W = $clog2(ROB_ENTRIES);

    // Dispatch to buffer
    logic                  full;
    logic [TAG_W-1:0]      alloc_tag;
    logic                  alloc_valid;
    op_t                   alloc_op;
    logic [REG_ADDR_W-1:0] alloc_rd;
    logic [XLEN-1:0]       alloc_link;
    logic [XLEN-1:0]       alloc_target;

    // Dispatch to execute
    logic                  iss_valid;
    op_t                   iss_op;
    logic [TAG_W-1:0]      iss_tag;
    logic [XLEN-1:0]       iss_a;
    logic [XLEN-1:0]       iss_b;

    // Common data bus
    logic                  cdb_fast_valid;
    logic [TAG_W-1:0]      cdb_fast_tag;
    logic [XLEN-1:0]       cdb_fast_value;
    logic                  cdb_slow_valid;
    logic [TAG_W-1:0]      cdb_slow_tag;
    logic [XLEN-1:0]       cdb_slow_value;

    // Buffer head and commit control
    logic                  head_valid;
    logic                  head_ready;
    op_t                   head_op;
    logic [REG_ADDR_W-1:0] head_rd;
    logic [XLEN-1:0]       head_value;
    logic [XLEN-1:0]       head_target;
    logic                  retire;
    logic                  flush;

    dispatch_stage #(
        .ROB_ENTRIES (ROB_ENTRIES)
    ) i_dispatch_stage (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_rd        (in_rd),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_target    (in_target),
        .in_ready     (in_ready),
        .full         (full),
        .alloc_tag    (alloc_tag),
        .flush        (flush),
        .alloc_valid  (alloc_valid),
        .alloc_op     (alloc_op),
        .alloc_rd     (alloc_rd),
        .alloc_link   (alloc_link),
        .alloc_target (alloc_target),
        .iss_valid    (iss_valid),
        .iss_op       (iss_op),
        .iss_tag      (iss_tag),
        .iss_a        (iss_a),
        .iss_b        (iss_b)
    );

    reorder_buffer #(
        .ROB_ENTRIES (ROB_ENTRIES)
    ) i_reorder_buffer (
        .clk            (clk),
        .reset          (reset),
        .alloc_valid    (alloc_valid),
        .alloc_op       (alloc_op),
        .alloc_rd       (alloc_rd),
        .alloc_link     (alloc_link),
        .alloc_target   (alloc_target),
        .full           (full),
        .alloc_tag      (alloc_tag),
        .cdb_fast_valid (cdb_fast_valid),
        .cdb_fast_tag   (cdb_fast_tag),
        .cdb_fast_value (cdb_fast_value),
        .cdb_slow_valid (cdb_slow_valid),
        .cdb_slow_tag   (cdb_slow_tag),
        .cdb_slow_value (cdb_slow_value),
        .retire         (retire),
        .flush          (flush),
        .head_valid     (head_valid),
        .head_ready     (head_ready),
        .head_op        (head_op),
        .head_rd        (head_rd),
        .head_value     (head_value),
        .head_target    (head_target)
    );

    exec_unit #(
        .ROB_ENTRIES (ROB_ENTRIES),
        .MUL_LATENCY (MUL_LATENCY)
    ) i_exec_unit (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .iss_valid      (iss_valid),
        .iss_op         (iss_op),
        .iss_tag        (iss_tag),
        .iss_a          (iss_a),
        .iss_b          (iss_b),
        .cdb_fast_valid (cdb_fast_valid),
        .cdb_fast_tag   (cdb_fast_tag),
        .cdb_fast_value (cdb_fast_value),
        .cdb_slow_valid (cdb_slow_valid),
        .cdb_slow_tag   (cdb_slow_tag),
        .cdb_slow_value (cdb_slow_value)
    );

    commit_stage i_commit_stage (
        .clk            (clk),
        .reset          (reset),
        .head_valid     (head_valid),
        .head_ready     (head_ready),
        .head_op        (head_op),
        .head_rd        (head_rd),
        .head_value     (head_value),
        .head_target    (head_target),
        .retire         (retire),
        .flush          (flush),
        .commit_valid   (commit_valid),
        .commit_op      (commit_op),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .rf_addr        (rf_addr),
        .rf_data        (rf_data)
    );

endmodule : ooo_backend

`default_nettype wire

// File: rtl/commit_stage.sv
`timescale 1ns/100ps
`default_nettype none

module commit_stage import rob_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,

    // Buffer head
    input  logic                   head_valid,
    input  logic                   head_ready,
    input  op_t                    head_op,
    input  logic [REG_ADDR_W-1:0]  head_rd,
    input  logic [XLEN-1:0]        head_value,
    input  logic [XLEN-1:0]        head_target,
    output logic                   retire,
    output logic                   flush,

    // Commit report
    output logic                   commit_valid,
    output op_t                    commit_op,
    output logic [REG_ADDR_W-1:0]  commit_rd,
    output logic [XLEN-1:0]        commit_value,

    // Redirect toward fetch
    output logic                   redirect_valid,
    output logic [XLEN-1:0]        redirect_pc,

    // Register file read port
    input  logic [REG_ADDR_W-1:0]  rf_addr,
    output logic [XLEN-1:0]        rf_data
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] rf [NUM_REGS];
    logic            writes_reg;
    logic            redirect;

    // Nothing retires in the flush cycle, the head is already a wrong-path entry
    assign retire = head_valid && head_ready && !flush;

    assign writes_reg = (head_op != op_br) && (head_rd != '0);
    assign redirect   = (head_op == op_jal) || ((head_op == op_br) && head_value[0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            flush        <= 1'b0;
        end else begin
            commit_valid <= retire;
            flush        <= retire && redirect;
        end
    end

    // Same pulse tells the outside where to fetch next
    assign redirect_valid = flush;

    always_ff @(posedge clk) begin
        if (retire) begin
            commit_op    <= head_op;
            commit_rd    <= head_rd;
            commit_value <= head_value;
            redirect_pc  <= head_target;
        end
    end

    // Architectural registers
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (retire && writes_reg) begin
            rf[head_rd] <= head_value;
        end
    end

    assign rf_data = (rf_addr == '0) ? '0 : rf[rf_addr];

endmodule : commit_stage

`default_nettype wire

// File: rtl/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exec_unit import rob_pkg::*; #(
    parameter int ROB_ENTRIES = 8,
    parameter int MUL_LATENCY = 3
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             flush,

    // Issue from dispatch
    input  logic                             iss_valid,
    input  op_t                              iss_op,
    input  logic [$clog2(ROB_ENTRIES)-1:0]   iss_tag,
    input  logic [XLEN-1:0]                  iss_a,
    input  logic [XLEN-1:0]                  iss_b,

    // Common data bus, fast port from the ALU lane
    output logic                             cdb_fast_valid,
    output logic [$clog2(ROB_ENTRIES)-1:0]   cdb_fast_tag,
    output logic [XLEN-1:0]                  cdb_fast_value,

    // Common data bus, slow port from the multiply lane
    output logic                             cdb_slow_valid,
    output logic [$clog2(ROB_ENTRIES)-1:0]   cdb_slow_tag,
    output logic [XLEN-1:0]                  cdb_slow_value
);

    localparam int TAG_W = $clog2(ROB_ENTRIES);

    logic             is_mul;
    logic [XLEN-1:0]  alu_result;
    logic [XLEN-1:0]  product;

    // Multiply shift pipeline, last stage drives the slow port
    logic [MUL_LATENCY-1:0] mul_valid;
    logic [TAG_W-1:0]       mul_tag   [MUL_LATENCY];
    logic [XLEN-1:0]        mul_value [MUL_LATENCY];

    assign is_mul  = (iss_op == op_mul);
    assign product = iss_a * iss_b;

    always_comb begin
        case (iss_op)
            op_add:  alu_result = iss_a + iss_b;
            op_xor:  alu_result = iss_a ^ iss_b;
            // Taken when operands are equal
            op_br:   alu_result = XLEN'(iss_a == iss_b);
            default: alu_result = '0;
        endcase
    end

    // Valid bits for both lanes
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            cdb_fast_valid <= 1'b0;
            mul_valid      <= '0;
        end else begin
            cdb_fast_valid <= iss_valid && !is_mul;
            mul_valid      <= {mul_valid[MUL_LATENCY-2:0], iss_valid && is_mul};
        end
    end

    // Lane payload
    always_ff @(posedge clk) begin
        cdb_fast_tag   <= iss_tag;
        cdb_fast_value <= alu_result;
        mul_tag[0]     <= iss_tag;
        mul_value[0]   <= product;
        for (int i = 1; i < MUL_LATENCY; i++) begin
            mul_tag[i]   <= mul_tag[i-1];
            mul_value[i] <= mul_value[i-1];
        end
    end

    assign cdb_slow_valid = mul_valid[MUL_LATENCY-1];
    assign cdb_slow_tag   = mul_tag[MUL_LATENCY-1];
    assign cdb_slow_value = mul_value[MUL_LATENCY-1];

endmodule : exec_unit

`default_nettype wire

// File: rtl/dispatch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_stage import rob_pkg::*; #(
    parameter int ROB_ENTRIES = 8
) (
    input  logic                             clk,
    input  logic                             reset,

    // Decoded instruction from outside
    input  logic                             in_valid,
    input  op_t                              in_op,
    input  logic [REG_ADDR_W-1:0]            in_rd,
    input  logic [XLEN-1:0]                  in_a,
    input  logic [XLEN-1:0]                  in_b,
    input  logic [XLEN-1:0]                  in_target,
    output logic                             in_ready,

    // Buffer allocation
    input  logic                             full,
    input  logic [$clog2(ROB_ENTRIES)-1:0]   alloc_tag,
    input  logic                             flush,
    output logic                             alloc_valid,
    output op_t                              alloc_op,
    output logic [REG_ADDR_W-1:0]            alloc_rd,
    output logic [XLEN-1:0]                  alloc_link,
    output logic [XLEN-1:0]                  alloc_target,

    // Issue to the execute lanes
    output logic                             iss_valid,
    output op_t                              iss_op,
    output logic [$clog2(ROB_ENTRIES)-1:0]   iss_tag,
    output logic [XLEN-1:0]                  iss_a,
    output logic [XLEN-1:0]                  iss_b
);

    localparam int TAG_W = $clog2(ROB_ENTRIES);

    // Holds input off until the first cycle after reset
    logic up;
    logic accept;

    assign in_ready = up && !full && !flush;
    assign accept   = in_valid && in_ready;

    // Entry is written into the buffer on the accept edge
    assign alloc_valid  = accept;
    assign alloc_op     = in_op;
    assign alloc_rd     = in_rd;
    assign alloc_link   = in_a;
    assign alloc_target = in_target;

    always_ff @(posedge clk) begin
        if (reset) begin
            up        <= 1'b0;
            iss_valid <= 1'b0;
        end else begin
            up        <= 1'b1;
            // Jumps complete in the buffer and never reach a lane
            iss_valid <= accept && (in_op != op_jal);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            iss_op  <= in_op;
            iss_tag <= TAG_W'(alloc_tag);
            iss_a   <= in_a;
            iss_b   <= in_b;
        end
    end

endmodule : dispatch_stage

`default_nettype wire

// File: rob/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer import rob_pkg::*; #(
    parameter int ROB_ENTRIES = 8
) (
    input  logic                             clk,
    input  logic                             reset,

    // Allocation from dispatch
    input  logic                             alloc_valid,
    input  op_t                              alloc_op,
    input  logic [REG_ADDR_W-1:0]            alloc_rd,
    input  logic [XLEN-1:0]                  alloc_link,
    input  logic [XLEN-1:0]                  alloc_target,
    output logic                             full,
    output logic [$clog2(ROB_ENTRIES)-1:0]   alloc_tag,

    // Common data bus
    input  logic                             cdb_fast_valid,
    input  logic [$clog2(ROB_ENTRIES)-1:0]   cdb_fast_tag,
    input  logic [XLEN-1:0]                  cdb_fast_value,
    input  logic                             cdb_slow_valid,
    input  logic [$clog2(ROB_ENTRIES)-1:0]   cdb_slow_tag,
    input  logic [XLEN-1:0]                  cdb_slow_value,

    // Head presentation to commit
    input  logic                             retire,
    input  logic                             flush,
    output logic                             head_valid,
    output logic                             head_ready,
    output op_t                              head_op,
    output logic [REG_ADDR_W-1:0]            head_rd,
    output logic [XLEN-1:0]                  head_value,
    output logic [XLEN-1:0]                  head_target
);

    localparam int TAG_W = $clog2(ROB_ENTRIES);

    // Per-entry control state
    logic [ROB_ENTRIES-1:0] entry_valid;
    logic [ROB_ENTRIES-1:0] entry_ready;

    // Per-entry payload
    op_t                   entry_op     [ROB_ENTRIES];
    logic [REG_ADDR_W-1:0] entry_rd     [ROB_ENTRIES];
    logic [XLEN-1:0]       entry_value  [ROB_ENTRIES];
    logic [XLEN-1:0]       entry_target [ROB_ENTRIES];

    logic [TAG_W-1:0] head_ptr;
    logic [TAG_W-1:0] tail_ptr;
    logic [TAG_W:0]   count;

    logic do_alloc;
    logic do_retire;
    logic fast_hit;
    logic slow_hit;

    assign full      = (count == (TAG_W+1)'(ROB_ENTRIES));
    assign alloc_tag = tail_ptr;

    assign do_alloc  = alloc_valid && !full;
    assign do_retire = retire && entry_valid[head_ptr];

    // A bus result is taken only by a live entry still waiting for it
    assign fast_hit = cdb_fast_valid && entry_valid[cdb_fast_tag] && !entry_ready[cdb_fast_tag];
    assign slow_hit = cdb_slow_valid && entry_valid[cdb_slow_tag] && !entry_ready[cdb_slow_tag];

    assign head_valid  = entry_valid[head_ptr];
    assign head_ready  = entry_ready[head_ptr];
    assign head_op     = entry_op[head_ptr];
    assign head_rd     = entry_rd[head_ptr];
    assign head_value  = entry_value[head_ptr];
    assign head_target = entry_target[head_ptr];

    // Pointers, occupancy and valid/ready flags
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_ptr    <= '0;
            tail_ptr    <= '0;
            count       <= '0;
            entry_valid <= '0;
            entry_ready <= '0;
        end else begin
            if (do_alloc) begin
                entry_valid[tail_ptr] <= 1'b1;
                // Jumps carry their link value, nothing to wait for
                entry_ready[tail_ptr] <= (alloc_op == op_jal);
                tail_ptr              <= tail_ptr + TAG_W'(1);
            end
            if (fast_hit) begin
                entry_ready[cdb_fast_tag] <= 1'b1;
            end
            if (slow_hit) begin
                entry_ready[cdb_slow_tag] <= 1'b1;
            end
            if (do_retire) begin
                entry_valid[head_ptr] <= 1'b0;
                entry_ready[head_ptr] <= 1'b0;
                head_ptr              <= head_ptr + TAG_W'(1);
            end
            count <= count + (TAG_W+1)'(do_alloc) - (TAG_W+1)'(do_retire);
        end
    end

    // Entry payload writes
    always_ff @(posedge clk) begin
        if (do_alloc) begin
            entry_op[tail_ptr]     <= alloc_op;
            entry_rd[tail_ptr]     <= alloc_rd;
            entry_value[tail_ptr]  <= alloc_link;
            entry_target[tail_ptr] <= alloc_target;
        end
        if (fast_hit) begin
            entry_value[cdb_fast_tag] <= cdb_fast_value;
        end
        if (slow_hit) begin
            entry_value[cdb_slow_tag] <= cdb_slow_value;
        end
    end

endmodule : reorder_buffer

`default_nettype wire

// File: common/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // Data word width
    localparam int XLEN = 32;

    // Eight architectural registers, x0 hardwired to zero
    localparam int REG_ADDR_W = 3;

    // Opcode field width
    localparam int OP_W = 3;

    // Decoded opcodes handled by the back end
    typedef enum logic [OP_W-1:0] {
        op_add = 3'd0,
        op_xor = 3'd1,
        op_mul = 3'd2,
        op_br  = 3'd3,
        op_jal = 3'd4
    } op_t;

endpackage : rob_pkg

`default_nettype wire
